//--- hdl/dw_cfg_pkg.sv
package dw_cfg_pkg;

  // Address and ID widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;

  // Wide upstream and narrow downstream data buses
  localparam int unsigned SlvDataWidth = 64;
  localparam int unsigned MstDataWidth = 32;

  // Bytes per beat on each side
  localparam int unsigned SlvStrbWidth = SlvDataWidth / 8;
  localparam int unsigned MstStrbWidth = MstDataWidth / 8;

  // Size code of one full narrow beat
  localparam int unsigned MstSizeLog = 2;

  // AXI burst type encoding
  localparam logic [1:0] BurstIncr = 2'b01;

  // AxCACHE bit 1 marks a transaction as modifiable
  localparam logic [3:0] CacheModifiable = 4'b0010;

  // Longest length a single AXI4 burst can carry
  localparam int unsigned MaxBurstLen = 255;

  // How a burst is carried across the converter
  typedef enum logic [1:0] {
    conv_passthrough,
    conv_incr_downsize
  } conv_mode_e;

  // Remaining narrow beats, room for twice 256 beats
  typedef logic [8:0] burst_len_t;

endpackage

//--- hdl/dw_chan_pkg.sv
package dw_chan_pkg;

  import dw_cfg_pkg::*;

  // Address channel, shared by AW and AR on both ports
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [3:0]           cache;
  } ax_chan_t;

  // Write data, wide side
  typedef struct packed {
    logic [SlvDataWidth-1:0] data;
    logic [SlvStrbWidth-1:0] strb;
    logic                    last;
  } slv_w_chan_t;

  // Write data, narrow side
  typedef struct packed {
    logic [MstDataWidth-1:0] data;
    logic [MstStrbWidth-1:0] strb;
    logic                    last;
  } mst_w_chan_t;

  // Write response, identical on both ports
  typedef struct packed {
    logic [IdWidth-1:0] id;
    logic [1:0]         resp;
  } b_chan_t;

  // Read data, wide side
  typedef struct packed {
    logic [IdWidth-1:0]      id;
    logic [SlvDataWidth-1:0] data;
    logic [1:0]              resp;
    logic                    last;
  } slv_r_chan_t;

  // Read data, narrow side
  typedef struct packed {
    logic [IdWidth-1:0]      id;
    logic [MstDataWidth-1:0] data;
    logic [1:0]              resp;
    logic                    last;
  } mst_r_chan_t;

  // Converted request plus the bookkeeping that both paths need
  typedef struct packed {
    ax_chan_t   ax;
    burst_len_t len;
    logic [2:0] size;
    conv_mode_e mode;
  } ax_plan_t;

endpackage

//--- hdl/burst_planner.sv
`timescale 1ns/1ps

module burst_planner
  import dw_cfg_pkg::*;
  import dw_chan_pkg::*;
(
  input  ax_chan_t ax_i,
  output ax_plan_t plan_o
);

  localparam int unsigned MstByteMask = MstStrbWidth - 1;

  logic [7:0]  beat_bytes;
  logic [7:0]  size_mask;
  logic [5:0]  ratio;
  logic [5:0]  align_adj;
  logic [14:0] conv_len;
  logic        downsize;

  // Bytes per wide beat and the offset bits inside it
  assign beat_bytes = 8'd1 << ax_i.size;
  assign size_mask  = beat_bytes - 8'd1;

  // Narrow beats per wide beat
  assign ratio = 6'(beat_bytes >> MstSizeLog);

  // Narrow beats skipped by an unaligned start address
  assign align_adj = 6'((ax_i.addr[7:0] & size_mask & ~8'(MstByteMask)) >> MstSizeLog);

  assign conv_len = (15'(ax_i.len) + 15'd1) * 15'(ratio) - 15'(align_adj) - 15'd1;

  // Only modifiable INCR bursts wider than the narrow bus get rewritten
  assign downsize = (|(ax_i.cache & CacheModifiable)) &&
                    (ax_i.burst == BurstIncr) &&
                    (ax_i.size > 3'(MstSizeLog));

  always_comb begin
    plan_o      = '0;
    plan_o.ax   = ax_i;
    plan_o.len  = burst_len_t'(ax_i.len);
    plan_o.size = ax_i.size;
    plan_o.mode = conv_passthrough;

    if (downsize) begin
      plan_o.ax.size = 3'(MstSizeLog);
      plan_o.ax.len  = conv_len[7:0];
      plan_o.len     = conv_len[8:0];
      plan_o.mode    = conv_incr_downsize;
    end
  end

  // Bursts that need splitting are not supported
  always_comb begin
    assert final (downsize !== 1'b1 || conv_len <= 15'(MaxBurstLen))
      else $error("burst_planner: converted length %0d exceeds one burst", conv_len);
  end

endmodule

//--- hdl/write_downsizer.sv
`timescale 1ns/1ps

module write_downsizer
  import dw_cfg_pkg::*;
  import dw_chan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ax_chan_t    slv_aw_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,
  input  slv_w_chan_t slv_w_i,
  input  logic        slv_w_valid_i,
  output logic        slv_w_ready_o,
  output ax_chan_t    mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  output mst_w_chan_t mst_w_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_passthrough,
    st_incr_downsize
  } state_e;

  state_e                state_q, state_d;
  ax_plan_t              plan_in;
  ax_plan_t              plan_q, plan_d;
  logic                  aw_valid_q, aw_valid_d;
  logic                  mst_w_hs;
  logic                  burst_done;
  logic                  beat_done;
  logic [AddrWidth-1:0]  beat_mask;
  logic [AddrWidth-1:0]  wide_mask;
  logic [AddrWidth-1:0]  addr_next;
  logic [MstSizeLog-1:0] mst_off;
  logic                  half;

  burst_planner burst_planner_inst (
    .ax_i  (slv_aw_i),
    .plan_o(plan_in)
  );

  // Next narrow address and whether it leaves the current wide beat
  assign beat_mask = (AddrWidth'(1) << plan_q.ax.size) - AddrWidth'(1);
  assign wide_mask = (AddrWidth'(1) << plan_q.size) - AddrWidth'(1);
  assign addr_next = (plan_q.ax.addr & ~beat_mask) + (AddrWidth'(1) << plan_q.ax.size);
  assign beat_done = (addr_next & ~wide_mask) != (plan_q.ax.addr & ~wide_mask);

  assign mst_off = plan_q.ax.addr[MstSizeLog-1:0];
  assign half    = plan_q.ax.addr[MstSizeLog];

  assign mst_aw_o       = plan_q.ax;
  assign mst_aw_valid_o = aw_valid_q;

  // W only flows once the downstream AW is gone
  assign mst_w_valid_o = (state_q != st_idle) && !aw_valid_q && slv_w_valid_i;
  assign mst_w_hs      = mst_w_valid_o && mst_w_ready_i;
  assign burst_done    = mst_w_hs && (plan_q.len == '0);

  assign slv_w_ready_o  = mst_w_hs &&
                          ((state_q == st_passthrough) || beat_done || (plan_q.len == '0));
  assign slv_aw_ready_o = (state_q == st_idle) || burst_done;

  // Pick the wide half that the narrow address points into
  always_comb begin
    int unsigned lane_base;
    lane_base    = half ? MstStrbWidth : 0;
    mst_w_o      = '0;
    mst_w_o.last = slv_w_i.last && (plan_q.len == '0);
    for (int n = 0; n < MstStrbWidth; n++) begin
      if (n >= int'(mst_off) && (n - int'(mst_off)) < (1 << plan_q.ax.size)) begin
        mst_w_o.data[8*n +: 8] = slv_w_i.data[8*(n + lane_base) +: 8];
        mst_w_o.strb[n]        = slv_w_i.strb[n + lane_base];
      end
    end
  end

  always_comb begin
    state_d    = state_q;
    plan_d     = plan_q;
    aw_valid_d = aw_valid_q;

    if (mst_aw_valid_o && mst_aw_ready_i) begin
      aw_valid_d = 1'b0;
    end

    if (mst_w_hs) begin
      plan_d.ax.addr = addr_next;
      plan_d.ax.len  = plan_q.ax.len - 8'd1;
      plan_d.len     = plan_q.len - 1'b1;
      if (plan_q.len == '0) begin
        state_d = st_idle;
      end
    end

    // A new burst may start on the last narrow beat of the old one
    if (slv_aw_valid_i && slv_aw_ready_o) begin
      plan_d     = plan_in;
      aw_valid_d = 1'b1;
      state_d    = (plan_in.mode == conv_incr_downsize) ? st_incr_downsize : st_passthrough;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= st_idle;
      aw_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    plan_q <= plan_d;
  end

  // Upstream AW holds while it waits, the planner reads it live
  a_slv_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_valid_i && !slv_aw_ready_o |=> slv_aw_valid_i && $stable(slv_aw_i));

  // Upstream last must agree with the converted length
  a_w_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_hs |-> (mst_w_o.last == (plan_q.len == '0)));

endmodule

//--- hdl/read_downsizer.sv
`timescale 1ns/1ps

module read_downsizer
  import dw_cfg_pkg::*;
  import dw_chan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ax_chan_t    slv_ar_i,
  input  logic        slv_ar_valid_i,
  output logic        slv_ar_ready_o,
  output slv_r_chan_t slv_r_o,
  output logic        slv_r_valid_o,
  input  logic        slv_r_ready_i,
  output ax_chan_t    mst_ar_o,
  output logic        mst_ar_valid_o,
  input  logic        mst_ar_ready_i,
  input  mst_r_chan_t mst_r_i,
  input  logic        mst_r_valid_i,
  output logic        mst_r_ready_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_passthrough,
    st_incr_downsize
  } state_e;

  state_e                state_q, state_d;
  ax_plan_t              plan_in;
  ax_plan_t              plan_q, plan_d;
  slv_r_chan_t           r_q, r_d;
  logic                  ar_valid_q, ar_valid_d;
  logic                  r_valid_q, r_valid_d;
  logic                  mst_r_hs;
  logic                  slv_r_hs;
  logic                  beat_done;
  logic [AddrWidth-1:0]  beat_mask;
  logic [AddrWidth-1:0]  wide_mask;
  logic [AddrWidth-1:0]  addr_next;
  logic [MstSizeLog-1:0] mst_off;
  logic                  half;

  burst_planner burst_planner_inst (
    .ax_i  (slv_ar_i),
    .plan_o(plan_in)
  );

  // Same address walk as the write side
  assign beat_mask = (AddrWidth'(1) << plan_q.ax.size) - AddrWidth'(1);
  assign wide_mask = (AddrWidth'(1) << plan_q.size) - AddrWidth'(1);
  assign addr_next = (plan_q.ax.addr & ~beat_mask) + (AddrWidth'(1) << plan_q.ax.size);
  assign beat_done = (addr_next & ~wide_mask) != (plan_q.ax.addr & ~wide_mask);

  assign mst_off = plan_q.ax.addr[MstSizeLog-1:0];
  assign half    = plan_q.ax.addr[MstSizeLog];

  assign mst_ar_o       = plan_q.ax;
  assign mst_ar_valid_o = ar_valid_q;
  assign slv_r_o        = r_q;
  assign slv_r_valid_o  = r_valid_q;

  assign slv_r_hs = r_valid_q && slv_r_ready_i;

  // Take a narrow beat only if the held wide beat can make room
  assign mst_r_ready_o = (state_q != st_idle) && !ar_valid_q &&
                         (!r_valid_q || slv_r_ready_i);
  assign mst_r_hs      = mst_r_valid_i && mst_r_ready_o;

  // One read in flight
  assign slv_ar_ready_o = (state_q == st_idle);

  always_comb begin
    int unsigned lane_base;
    lane_base  = half ? MstStrbWidth : 0;
    state_d    = state_q;
    plan_d     = plan_q;
    r_d        = r_q;
    ar_valid_d = ar_valid_q;
    r_valid_d  = r_valid_q;

    if (mst_ar_valid_o && mst_ar_ready_i) begin
      ar_valid_d = 1'b0;
    end

    if (slv_r_hs) begin
      r_valid_d = 1'b0;
      if (r_q.last) begin
        state_d = st_idle;
      end
    end

    if (mst_r_hs) begin
      for (int n = 0; n < MstStrbWidth; n++) begin
        if (n >= int'(mst_off) && (n - int'(mst_off)) < (1 << plan_q.ax.size)) begin
          r_d.data[8*(n + lane_base) +: 8] = mst_r_i.data[8*n +: 8];
        end
      end
      r_d.id   = mst_r_i.id;
      r_d.resp = mst_r_i.resp;
      r_d.last = (plan_q.len == '0);

      plan_d.ax.addr = addr_next;
      plan_d.ax.len  = plan_q.ax.len - 8'd1;
      plan_d.len     = plan_q.len - 1'b1;

      // Hand up a wide beat once it is full or the burst ends
      if ((state_q == st_passthrough) || beat_done || (plan_q.len == '0)) begin
        r_valid_d = 1'b1;
      end
    end

    if (slv_ar_valid_i && slv_ar_ready_o) begin
      plan_d     = plan_in;
      ar_valid_d = 1'b1;
      state_d    = (plan_in.mode == conv_incr_downsize) ? st_incr_downsize : st_passthrough;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= st_idle;
      ar_valid_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      ar_valid_q <= ar_valid_d;
      r_valid_q  <= r_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    plan_q <= plan_d;
    r_q    <= r_d;
  end

  // A stalled wide beat must not be overwritten by later narrow beats
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o && $stable(slv_r_o));

endmodule

//--- hdl/axi_dw_downsizer.sv
`timescale 1ns/1ps

module axi_dw_downsizer
  import dw_chan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Wide upstream port
  input  ax_chan_t    slv_aw_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,
  input  slv_w_chan_t slv_w_i,
  input  logic        slv_w_valid_i,
  output logic        slv_w_ready_o,
  output b_chan_t     slv_b_o,
  output logic        slv_b_valid_o,
  input  logic        slv_b_ready_i,
  input  ax_chan_t    slv_ar_i,
  input  logic        slv_ar_valid_i,
  output logic        slv_ar_ready_o,
  output slv_r_chan_t slv_r_o,
  output logic        slv_r_valid_o,
  input  logic        slv_r_ready_i,
  // Narrow downstream port
  output ax_chan_t    mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  output mst_w_chan_t mst_w_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i,
  input  b_chan_t     mst_b_i,
  input  logic        mst_b_valid_i,
  output logic        mst_b_ready_o,
  output ax_chan_t    mst_ar_o,
  output logic        mst_ar_valid_o,
  input  logic        mst_ar_ready_i,
  input  mst_r_chan_t mst_r_i,
  input  logic        mst_r_valid_i,
  output logic        mst_r_ready_o
);

  write_downsizer write_downsizer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_aw_i      (slv_aw_i),
    .slv_aw_valid_i(slv_aw_valid_i),
    .slv_aw_ready_o(slv_aw_ready_o),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_aw_o      (mst_aw_o),
    .mst_aw_valid_o(mst_aw_valid_o),
    .mst_aw_ready_i(mst_aw_ready_i),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  read_downsizer read_downsizer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_ar_i      (slv_ar_i),
    .slv_ar_valid_i(slv_ar_valid_i),
    .slv_ar_ready_o(slv_ar_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .mst_ar_o      (mst_ar_o),
    .mst_ar_valid_o(mst_ar_valid_o),
    .mst_ar_ready_i(mst_ar_ready_i),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o)
  );

  // B carries one response per burst, so it crosses unchanged
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

//--- verif/narrow_mem_model.sv
`timescale 1ns/1ps

module narrow_mem_model
  import dw_cfg_pkg::*;
  import dw_chan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ax_chan_t    aw_i,
  input  logic        aw_valid_i,
  output logic        aw_ready_o,
  input  mst_w_chan_t w_i,
  input  logic        w_valid_i,
  output logic        w_ready_o,
  output b_chan_t     b_o,
  output logic        b_valid_o,
  input  logic        b_ready_i,
  input  ax_chan_t    ar_i,
  input  logic        ar_valid_i,
  output logic        ar_ready_o,
  output mst_r_chan_t r_o,
  output logic        r_valid_o,
  input  logic        r_ready_i
);

  localparam int unsigned MemBytes = 4096;

  logic [7:0] mem [MemBytes];
  ax_chan_t   wr_q;
  ax_chan_t   rd_q;
  logic       wr_busy_q;
  logic       rd_busy_q;

  // INCR address step, aligned to the beat size
  function automatic logic [AddrWidth-1:0] next_addr(input ax_chan_t ax);
    logic [AddrWidth-1:0] inc;
    inc = AddrWidth'(1) << ax.size;
    return (ax.addr & ~(inc - AddrWidth'(1))) + inc;
  endfunction

  assign aw_ready_o = !wr_busy_q && !b_valid_o;
  assign w_ready_o  = wr_busy_q;
  assign ar_ready_o = !rd_busy_q;
  assign r_valid_o  = rd_busy_q;

  // Fill pattern mixes every address bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_q      <= '0;
      wr_busy_q <= 1'b0;
      b_o       <= '0;
      b_valid_o <= 1'b0;
      for (int i = 0; i < MemBytes; i++) begin
        mem[i] <= 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
      end
    end else begin
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (aw_valid_i && aw_ready_o) begin
        wr_q      <= aw_i;
        wr_busy_q <= 1'b1;
      end
      if (w_valid_i && w_ready_o) begin
        for (int n = 0; n < MstStrbWidth; n++) begin
          if (w_i.strb[n]) begin
            mem[{wr_q.addr[11:2], 2'(n)}] <= w_i.data[8*n +: 8];
          end
        end
        wr_q.addr <= next_addr(wr_q);
        // One response per burst
        if (w_i.last) begin
          wr_busy_q <= 1'b0;
          b_o       <= '{id: wr_q.id, resp: 2'b00};
          b_valid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q      <= '0;
      rd_busy_q <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      rd_q      <= ar_i;
      rd_busy_q <= 1'b1;
    end else if (r_valid_o && r_ready_i) begin
      rd_q.addr <= next_addr(rd_q);
      rd_q.len  <= rd_q.len - 8'd1;
      rd_busy_q <= (rd_q.len != 8'd0);
    end
  end

  // Whole word returned, the DUT picks its lanes
  always_comb begin
    r_o      = '0;
    r_o.id   = rd_q.id;
    r_o.last = (rd_q.len == 8'd0);
    for (int n = 0; n < MstStrbWidth; n++) begin
      r_o.data[8*n +: 8] = mem[{rd_q.addr[11:2], 2'(n)}];
    end
  end

endmodule

//--- verif/tb_axi_dw_downsizer.sv
`timescale 1ns/1ps

module tb_axi_dw_downsizer
  import dw_cfg_pkg::*;
  import dw_chan_pkg::*;
();

  localparam int unsigned MemBytes = 4096;
  localparam int unsigned Timeout  = 200;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  ax_chan_t    slv_aw_i, slv_ar_i, mst_aw_o, mst_ar_o;
  slv_w_chan_t slv_w_i;
  mst_w_chan_t mst_w_o;
  b_chan_t     slv_b_o, mst_b_i;
  slv_r_chan_t slv_r_o;
  mst_r_chan_t mst_r_i;
  logic        slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o;
  logic        slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic        slv_r_valid_o, slv_r_ready_i;
  logic        mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic        mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic        mst_r_valid_i, mst_r_ready_o;

  logic [31:0] lfsr_q;
  logic [7:0]  exp_mem [MemBytes];

  always #5 clk_i = ~clk_i;

  axi_dw_downsizer axi_dw_downsizer_inst (.*);

  narrow_mem_model narrow_mem_model_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .aw_i      (mst_aw_o),
    .aw_valid_i(mst_aw_valid_o),
    .aw_ready_o(mst_aw_ready_i),
    .w_i       (mst_w_o),
    .w_valid_i (mst_w_valid_o),
    .w_ready_o (mst_w_ready_i),
    .b_o       (mst_b_i),
    .b_valid_o (mst_b_valid_i),
    .b_ready_i (mst_b_ready_o),
    .ar_i      (mst_ar_o),
    .ar_valid_i(mst_ar_valid_o),
    .ar_ready_o(mst_ar_ready_i),
    .r_o       (mst_r_i),
    .r_valid_o (mst_r_valid_i),
    .r_ready_i (mst_r_ready_o)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] take_bits(input int unsigned n);
    logic [63:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      bits[i] = lfsr_q[0];
      lfsr_q  = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_ax(input bit is_read, input ax_chan_t ax);
    int unsigned cycles;
    cycles = 0;
    if (is_read) begin
      slv_ar_i       = ax;
      slv_ar_valid_i = 1'b1;
    end else begin
      slv_aw_i       = ax;
      slv_aw_valid_i = 1'b1;
    end
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) stop_on_error("address handshake on the wide port timed out");
    end while (!(is_read ? slv_ar_ready_o : slv_aw_ready_o));
    step();
    slv_ar_valid_i = 1'b0;
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic check_narrow_ax(input bit is_read, input ax_chan_t orig,
                                 input logic [7:0] len, input logic [2:0] size);
    int unsigned cycles;
    ax_chan_t    ax;
    string       port;
    cycles = 0;
    port   = is_read ? "mst_ar_o" : "mst_aw_o";
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) stop_on_error("no request appeared on the narrow port");
    end while (!(is_read ? mst_ar_valid_o : mst_aw_valid_o));
    ax = is_read ? mst_ar_o : mst_aw_o;
    // Only len and size may be rewritten
    check_eq({port, ".id"}, 64'(ax.id), 64'(orig.id));
    check_eq({port, ".addr"}, 64'(ax.addr), 64'(orig.addr));
    check_eq({port, ".len"}, 64'(ax.len), 64'(len));
    check_eq({port, ".size"}, 64'(ax.size), 64'(size));
    check_eq({port, ".burst"}, 64'(ax.burst), 64'(orig.burst));
    check_eq({port, ".cache"}, 64'(ax.cache), 64'(orig.cache));
    step();
  endtask

  task automatic write_burst(input ax_chan_t aw, input logic [7:0] exp_len,
                             input logic [2:0] exp_size);
    int unsigned          cycles;
    int                   lo;
    int                   hi;
    logic [AddrWidth-1:0] addr;
    logic [63:0]          wdata;
    logic [7:0]           wstrb;
    send_ax(1'b0, aw);
    check_narrow_ax(1'b0, aw, exp_len, exp_size);
    addr = aw.addr;
    for (int i = 0; i <= int'(aw.len); i++) begin
      wdata = take_bits(64);
      wstrb = 8'(take_bits(8));
      // Active lanes of this wide beat
      lo = int'(addr[2:0]);
      hi = (lo & ~((1 << int'(aw.size)) - 1)) + (1 << int'(aw.size));
      for (int k = lo; k < hi; k++) begin
        if (wstrb[k]) exp_mem[{addr[11:3], 3'(k)}] = wdata[8*k +: 8];
      end
      slv_w_i       = '{data: wdata, strb: wstrb, last: (i == int'(aw.len))};
      slv_w_valid_i = 1'b1;
      cycles        = 0;
      do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > Timeout) stop_on_error("wide W beat was never accepted");
      end while (!slv_w_ready_o);
      step();
      addr = (addr & ~((32'd1 << aw.size) - 32'd1)) + (32'd1 << aw.size);
    end
    slv_w_valid_i = 1'b0;
    slv_b_ready_i = 1'b1;
    cycles        = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) stop_on_error("write response never arrived");
    end while (!slv_b_valid_o);
    check_eq("slv_b_o.id", 64'(slv_b_o.id), 64'(aw.id));
    check_eq("slv_b_o.resp", 64'(slv_b_o.resp), 64'd0);
    step();
    slv_b_ready_i = 1'b0;
  endtask

  task automatic read_burst(input ax_chan_t ar, input logic [7:0] exp_len,
                            input logic [2:0] exp_size, input int unsigned beats,
                            input bit rand_ready);
    int unsigned          cycles;
    int unsigned          idx;
    int                   lo;
    int                   hi;
    logic [AddrWidth-1:0] addr;
    logic [63:0]          coin;
    send_ax(1'b1, ar);
    check_narrow_ax(1'b1, ar, exp_len, exp_size);
    addr          = ar.addr;
    idx           = 0;
    cycles        = 0;
    slv_r_ready_i = 1'b1;
    while (idx < beats) begin
      @(negedge clk_i);
      if (slv_r_valid_o && slv_r_ready_i) begin
        lo = int'(addr[2:0]);
        hi = (lo & ~((1 << int'(ar.size)) - 1)) + (1 << int'(ar.size));
        for (int k = lo; k < hi; k++) begin
          check_eq($sformatf("slv_r_o.data[%0d +: 8] beat %0d", 8 * k, idx),
                   64'(slv_r_o.data[8*k +: 8]), 64'(exp_mem[{addr[11:3], 3'(k)}]));
        end
        check_eq("slv_r_o.id", 64'(slv_r_o.id), 64'(ar.id));
        check_eq("slv_r_o.resp", 64'(slv_r_o.resp), 64'd0);
        check_eq("slv_r_o.last", 64'(slv_r_o.last), 64'(idx == beats - 1));
        addr = (addr & ~((32'd1 << ar.size) - 32'd1)) + (32'd1 << ar.size);
        idx++;
      end
      step();
      if (rand_ready) begin
        coin          = take_bits(1);
        slv_r_ready_i = coin[0];
      end
      cycles++;
      if (cycles > Timeout) stop_on_error("wide R beats stopped arriving");
    end
    slv_r_ready_i = 1'b0;
    // No extra beat after the last one
    @(negedge clk_i);
    check_eq("slv_r_valid_o", 64'(slv_r_valid_o), 64'd0);
    check_eq("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'd1);
    step();
  endtask

  task automatic check_mem(input int unsigned lo, input int unsigned hi);
    for (int unsigned a = lo; a <= hi; a++) begin
      check_eq($sformatf("mem[%0h]", a), 64'(narrow_mem_model_inst.mem[a]), 64'(exp_mem[a]));
    end
  endtask

  task automatic idle_after_reset();
    @(negedge clk_i);
    check_eq("slv_aw_ready_o", 64'(slv_aw_ready_o), 64'd1);
    check_eq("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'd1);
    check_eq("slv_w_ready_o", 64'(slv_w_ready_o), 64'd0);
    check_eq("slv_b_valid_o", 64'(slv_b_valid_o), 64'd0);
    check_eq("slv_r_valid_o", 64'(slv_r_valid_o), 64'd0);
    check_eq("mst_aw_valid_o", 64'(mst_aw_valid_o), 64'd0);
    check_eq("mst_w_valid_o", 64'(mst_w_valid_o), 64'd0);
    check_eq("mst_b_ready_o", 64'(mst_b_ready_o), 64'd0);
    check_eq("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'd0);
    check_eq("mst_r_ready_o", 64'(mst_r_ready_o), 64'd0);
    step();
  endtask

  task automatic downsized_write();
    write_burst('{id: 4'h5, addr: 32'h100, len: 8'd3, size: 3'd3, burst: BurstIncr,
                  cache: CacheModifiable}, 8'd7, 3'd2);
    check_mem(32'h100, 32'h11f);
  endtask

  task automatic downsized_read();
    read_burst('{id: 4'h9, addr: 32'h100, len: 8'd3, size: 3'd3, burst: BurstIncr,
                 cache: CacheModifiable}, 8'd7, 3'd2, 4, 1'b0);
  endtask

  // Starts 4 bytes into a wide beat and drops one narrow beat
  task automatic unaligned_read();
    read_burst('{id: 4'h3, addr: 32'h104, len: 8'd1, size: 3'd3, burst: BurstIncr,
                 cache: CacheModifiable}, 8'd2, 3'd2, 2, 1'b0);
  endtask

  task automatic passthrough_round_trip();
    ax_chan_t ax;
    ax = '{id: 4'ha, addr: 32'h200, len: 8'd3, size: 3'd2, burst: BurstIncr, cache: 4'h0};
    write_burst(ax, 8'd3, 3'd2);
    check_mem(32'h200, 32'h20f);
    read_burst(ax, 8'd3, 3'd2, 4, 1'b0);
  endtask

  task automatic read_with_backpressure();
    read_burst('{id: 4'hc, addr: 32'h100, len: 8'd7, size: 3'd3, burst: BurstIncr,
                 cache: CacheModifiable}, 8'd15, 3'd2, 8, 1'b1);
  endtask

  initial begin
    lfsr_q = 32'ha3bf_1738;
    for (int i = 0; i < MemBytes; i++) begin
      exp_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
    end
    rst_ni         = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    idle_after_reset();
    downsized_write();
    downsized_read();
    unaligned_read();
    passthrough_round_trip();
    read_with_backpressure();

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- build.f
hdl/dw_cfg_pkg.sv
hdl/dw_chan_pkg.sv
hdl/burst_planner.sv
hdl/write_downsizer.sv
hdl/read_downsizer.sv
hdl/axi_dw_downsizer.sv
verif/narrow_mem_model.sv
verif/tb_axi_dw_downsizer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_dw_downsizer -f build.f

./obj_dir/Vtb_axi_dw_downsizer | tee sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
